// File: src/seq_consts.svh
`ifndef SEQ_CONSTS_SVH
`define SEQ_CONSTS_SVH

//////////////////////////////////////////////////
// Instruction stream
//////////////////////////////////////////////////

// Width of one streamed instruction word
`define SEQ_INST_WIDTH 24
// Instruction memory address bits, 32 words
`define SEQ_IM_ADDR_WIDTH 5
// Cycles from word accept to replay request
`define SEQ_REPLAY_DELAY 9

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

// Register and result width
`define SEQ_DATA_WIDTH 16
// Register index bits, four registers
`define SEQ_REG_SEL_WIDTH 2

`endif

// File: src/seq_pkg.sv
`include "seq_consts.svh"

package seq_pkg;

    // Immediate gets whatever the fixed fields leave over
    localparam int IMM_WIDTH = `SEQ_INST_WIDTH - 4 - 3 * `SEQ_REG_SEL_WIDTH;

    // Opcode encodings
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LDI  = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_MUL  = 4'd4,
        OP_EMIT = 4'd5
    } opcode_e;

    // Streamed instruction word, opcode in the top bits
    typedef struct packed {
        logic [3:0]                    opcode;
        logic [`SEQ_REG_SEL_WIDTH-1:0] dst;
        logic [`SEQ_REG_SEL_WIDTH-1:0] src_a;
        logic [`SEQ_REG_SEL_WIDTH-1:0] src_b;
        logic [IMM_WIDTH-1:0]          imm;
    } inst_word_t;

    // Decoded control for the execution stage
    typedef struct packed {
        logic                          valid;
        opcode_e                       op;
        logic [`SEQ_REG_SEL_WIDTH-1:0] dst;
        logic [`SEQ_REG_SEL_WIDTH-1:0] src_a;
        logic [`SEQ_REG_SEL_WIDTH-1:0] src_b;
        // Zero-extended immediate
        logic [`SEQ_DATA_WIDTH-1:0]    imm;
        // Register write-back request
        logic                          wr_en;
        // Drive src_a to the result port
        logic                          emit;
    } dec_ctrl_t;

endpackage

// File: src/inst_mem.sv
`timescale 1ns/1ns
`include "seq_consts.svh"

module inst_mem (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_in_v,
    input  seq_pkg::inst_word_t inst_in,
    output logic                inst_out_v,
    output seq_pkg::inst_word_t inst_out
);
    import seq_pkg::*;

    localparam int AW    = `SEQ_IM_ADDR_WIDTH;
    localparam int DEPTH = 2 ** `SEQ_IM_ADDR_WIDTH;
    localparam int DLY   = `SEQ_REPLAY_DELAY;

    //////////////////////////////////////////////////
    // Replay window control
    //////////////////////////////////////////////////

    // Delayed copy of the input valid
    logic [DLY-1:0] delay_sr;
    logic           window_open;
    logic           window_d1;
    logic           window_d2;
    // Window plus one drain cycle
    logic           window;

    // Write side
    logic           wr_en;
    logic           wr_en_r;
    logic           burst_start;
    logic [AW-1:0]  wr_addr;
    // First address of the most recent burst
    logic [AW-1:0]  base_addr;

    // Read side, pc is an offset inside the window
    logic [AW-1:0]  pc;
    // Shared registered address for read and write
    logic [AW-1:0]  mem_addr;

    inst_word_t     inst_in_r;
    inst_word_t     imem [DEPTH];

    assign window_open = delay_sr[DLY-1];
    assign window      = window_open | window_d1;
    // Writes are blocked while replaying
    assign wr_en       = inst_in_v & ~window;
    // First word of a burst, valid was low last cycle
    assign burst_start = wr_en & ~delay_sr[0];
    // Read data lags the window by two registers
    assign inst_out_v  = window_d2;

    always_ff @(posedge clk) begin
        if (rst) begin
            delay_sr  <= '0;
            window_d1 <= 1'b0;
            window_d2 <= 1'b0;
            wr_en_r   <= 1'b0;
            wr_addr   <= '0;
            base_addr <= '0;
            pc        <= '0;
            mem_addr  <= '0;
        end else begin
            delay_sr  <= {delay_sr[DLY-2:0], inst_in_v};
            window_d1 <= window_open;
            window_d2 <= window_d1;
            wr_en_r   <= wr_en;
            if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (burst_start) begin
                base_addr <= wr_addr;
            end
            // Program counter only runs inside the window
            if (window) begin
                pc <= pc + 1'b1;
            end else begin
                pc <= '0;
            end
            // Read address during replay, else next write slot
            mem_addr <= window ? base_addr + pc : wr_addr;
        end
    end

    //////////////////////////////////////////////////
    // Block-style storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        inst_in_r <= inst_in;
        if (wr_en_r) begin
            imem[mem_addr] <= inst_in_r;
        end
        // Registered read
        inst_out <= imem[mem_addr];
    end

endmodule

// File: src/inst_decode.sv
`timescale 1ns/1ns
`include "seq_consts.svh"

module inst_decode (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                in_v,
    input  seq_pkg::inst_word_t                 in_word,
    output seq_pkg::dec_ctrl_t                  dec,
    output logic [`SEQ_REG_SEL_WIDTH-1:0]       rd_sel_a,
    output logic [`SEQ_REG_SEL_WIDTH-1:0]       rd_sel_b
);
    import seq_pkg::*;

    dec_ctrl_t dec_nxt;
    opcode_e   op_raw;

    // Raw opcode field as an enum
    assign op_raw = opcode_e'(in_word.opcode);

    always_comb begin
        dec_nxt       = '0;
        dec_nxt.valid = in_v;
        dec_nxt.dst   = in_word.dst;
        dec_nxt.src_a = in_word.src_a;
        dec_nxt.src_b = in_word.src_b;
        // Zero extension for LDI
        dec_nxt.imm   = {{(`SEQ_DATA_WIDTH - IMM_WIDTH){1'b0}}, in_word.imm};
        case (op_raw)
            OP_LDI, OP_ADD, OP_SUB, OP_MUL: begin
                dec_nxt.op    = op_raw;
                dec_nxt.wr_en = 1'b1;
            end
            OP_EMIT: begin
                dec_nxt.op   = op_raw;
                dec_nxt.emit = 1'b1;
            end
            // NOP and unknown codes
            default: begin
                dec_nxt.op = OP_NOP;
            end
        endcase
    end

    // One register stage
    always_ff @(posedge clk) begin
        if (rst) begin
            dec <= '0;
        end else begin
            dec <= dec_nxt;
        end
    end

    // Selects from the registered fields so read data lines up with dec
    assign rd_sel_a = dec.src_a;
    assign rd_sel_b = dec.src_b;

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns
`include "seq_consts.svh"

module reg_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`SEQ_REG_SEL_WIDTH-1:0] rd_sel_a,
    input  logic [`SEQ_REG_SEL_WIDTH-1:0] rd_sel_b,
    output logic [`SEQ_DATA_WIDTH-1:0]    rd_data_a,
    output logic [`SEQ_DATA_WIDTH-1:0]    rd_data_b,
    input  logic                          wr_en,
    input  logic [`SEQ_REG_SEL_WIDTH-1:0] wr_sel,
    input  logic [`SEQ_DATA_WIDTH-1:0]    wr_data
);

    localparam int NREGS = 2 ** `SEQ_REG_SEL_WIDTH;

    logic [`SEQ_DATA_WIDTH-1:0] regs [NREGS];

    // Single write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

    //////////////////////////////////////////////////
    // Read ports with same-cycle write bypass
    //////////////////////////////////////////////////

    // Lets a dependent instruction right behind the writer see the new value
    always_comb begin
        if (wr_en && (wr_sel == rd_sel_a)) begin
            rd_data_a = wr_data;
        end else begin
            rd_data_a = regs[rd_sel_a];
        end
        if (wr_en && (wr_sel == rd_sel_b)) begin
            rd_data_b = wr_data;
        end else begin
            rd_data_b = regs[rd_sel_b];
        end
    end

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ns
`include "seq_consts.svh"

module exec_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  seq_pkg::dec_ctrl_t            dec,
    input  logic [`SEQ_DATA_WIDTH-1:0]    rd_data_a,
    input  logic [`SEQ_DATA_WIDTH-1:0]    rd_data_b,
    output logic                          wr_en,
    output logic [`SEQ_REG_SEL_WIDTH-1:0] wr_sel,
    output logic [`SEQ_DATA_WIDTH-1:0]    wr_data,
    output logic                          result_v,
    output logic [`SEQ_DATA_WIDTH-1:0]    result
);
    import seq_pkg::*;

    // Full product, only the low half is kept
    logic [2*`SEQ_DATA_WIDTH-1:0] product;
    logic [`SEQ_DATA_WIDTH-1:0]   alu_out;

    assign product = rd_data_a * rd_data_b;

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////

    always_comb begin
        case (dec.op)
            OP_LDI: begin
                alu_out = dec.imm;
            end
            // Add and subtract wrap at 16 bits
            OP_ADD: begin
                alu_out = rd_data_a + rd_data_b;
            end
            OP_SUB: begin
                alu_out = rd_data_a - rd_data_b;
            end
            OP_MUL: begin
                alu_out = product[`SEQ_DATA_WIDTH-1:0];
            end
            // No arithmetic for NOP or EMIT
            default: begin
                alu_out = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Write-back and result registers
    //////////////////////////////////////////////////

    // Strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en    <= 1'b0;
            result_v <= 1'b0;
        end else begin
            wr_en    <= dec.valid & dec.wr_en;
            result_v <= dec.valid & dec.emit;
        end
    end

    // Payload follows the strobes by the same cycle
    always_ff @(posedge clk) begin
        wr_sel  <= dec.dst;
        wr_data <= alu_out;
        // EMIT sends src_a out
        result  <= rd_data_a;
    end

endmodule

// File: src/seq_top.sv
`timescale 1ns/1ns
`include "seq_consts.svh"

module seq_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       inst_in_v,
    input  seq_pkg::inst_word_t        inst_in,
    output logic                       result_v,
    output logic [`SEQ_DATA_WIDTH-1:0] result
);
    import seq_pkg::*;

    // Memory to decoder
    logic                          im_out_v;
    inst_word_t                    im_out;

    // Decoder to execution and register file
    dec_ctrl_t                     dec;
    logic [`SEQ_REG_SEL_WIDTH-1:0] rd_sel_a;
    logic [`SEQ_REG_SEL_WIDTH-1:0] rd_sel_b;
    logic [`SEQ_DATA_WIDTH-1:0]    rd_data_a;
    logic [`SEQ_DATA_WIDTH-1:0]    rd_data_b;

    // Write-back path
    logic                          wr_en;
    logic [`SEQ_REG_SEL_WIDTH-1:0] wr_sel;
    logic [`SEQ_DATA_WIDTH-1:0]    wr_data;

    inst_mem im0 (
        .clk        (clk),
        .rst        (rst),
        .inst_in_v  (inst_in_v),
        .inst_in    (inst_in),
        .inst_out_v (im_out_v),
        .inst_out   (im_out)
    );

    inst_decode dec0 (
        .clk      (clk),
        .rst      (rst),
        .in_v     (im_out_v),
        .in_word  (im_out),
        .dec      (dec),
        .rd_sel_a (rd_sel_a),
        .rd_sel_b (rd_sel_b)
    );

    reg_file rf0 (
        .clk       (clk),
        .rst       (rst),
        .rd_sel_a  (rd_sel_a),
        .rd_sel_b  (rd_sel_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .wr_data   (wr_data)
    );

    exec_unit ex0 (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .wr_data   (wr_data),
        .result_v  (result_v),
        .result    (result)
    );

endmodule

// File: sim/seq_chk.sv
`timescale 1ns/1ns
`include "seq_consts.svh"

module seq_chk (
    input logic                          clk,
    input logic                          rst,
    input logic                          inst_in_v,
    input seq_pkg::inst_word_t           inst_in,
    input logic                          inst_out_v,
    input logic                          result_v,
    input logic [`SEQ_IM_ADDR_WIDTH-1:0] wr_addr
);
    import seq_pkg::*;

    localparam int DLY   = `SEQ_REPLAY_DELAY;
    localparam int DEPTH = 2 ** `SEQ_IM_ADDR_WIDTH;
    // Deepest look-back below
    localparam int HIST  = DLY + 4;

    // Saturating cycle count, every $past backed by real samples once full
    int   hist_cnt = 0;
    logic hist_ok;
    // EMIT word accepted this cycle
    logic emit_in;
    // Words accepted since reset
    int   acc_cnt = 0;

    // Failure tallies per assertion
    int reset_fails  = 0;
    int replay_fails = 0;
    int result_fails = 0;
    int addr_fails   = 0;
    int fail_cnt;

    assign hist_ok  = (hist_cnt >= HIST);
    assign emit_in  = inst_in_v && (inst_in.opcode == OP_EMIT);
    assign fail_cnt = reset_fails + replay_fails + result_fails + addr_fails;

    always @(posedge clk) begin
        if (hist_cnt < HIST) begin
            hist_cnt <= hist_cnt + 1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            acc_cnt <= 0;
        end else if (inst_in_v) begin
            acc_cnt <= acc_cnt + 1;
        end
    end

    //////////////////////////////////////////////////
    // Protocol and latency properties
    //////////////////////////////////////////////////

    // Outputs idle in the first cycle out of reset
    reset_quiet: assert property (@(posedge clk) $past(rst) && !rst |-> !result_v && !inst_out_v)
        else begin
            reset_fails++;
            $error("result_v or inst_out_v high right after reset");
        end

    // Replay valid is the input valid, DLY + 2 cycles later
    replay_lat: assert property (@(posedge clk) disable iff (rst)
        hist_ok |-> inst_out_v == $past(inst_in_v, DLY + 2))
        else begin
            replay_fails++;
            $error("inst_out_v does not follow inst_in_v by the replay latency");
        end

    // One result per EMIT, DLY + 4 cycles after acceptance
    result_lat: assert property (@(posedge clk) disable iff (rst)
        hist_ok |-> result_v == $past(emit_in, DLY + 4))
        else begin
            result_fails++;
            $error("result_v does not follow an EMIT word by the result latency");
        end

    // Each accepted word takes the next address, wrapping inside the memory
    addr_track: assert property (@(posedge clk) disable iff (rst)
        int'(wr_addr) == acc_cnt % DEPTH)
        else begin
            addr_fails++;
            $error("write address does not track the accepted words");
        end

endmodule

bind seq_top seq_chk chk0 (
    .clk        (clk),
    .rst        (rst),
    .inst_in_v  (inst_in_v),
    .inst_in    (inst_in),
    .inst_out_v (im_out_v),
    .result_v   (result_v),
    .wr_addr    (im0.wr_addr)
);

// File: sim/seq_tb.sv
`timescale 1ns/1ns
`include "seq_consts.svh"

module seq_tb;
    import seq_pkg::*;

    localparam int DW = `SEQ_DATA_WIDTH;
    // Replay window shuts writes after DLY words, so no burst goes longer
    localparam int MAX_BURST = `SEQ_REPLAY_DELAY;
    // Reset and idle ~25, five bursts of at most 9 + 13 drain + 13 gap, doubled
    localparam int TIMEOUT_CYCLES = 400;

    logic          clk;
    logic          rst;
    logic          inst_in_v;
    inst_word_t    inst_in;
    logic          result_v;
    logic [DW-1:0] result;

    // Reference register file and expected results in emit order
    logic [DW-1:0] model_regs [4];
    logic [DW-1:0] exp_q [$];
    inst_word_t    burst_q [$];
    logic [DW-1:0] exp_val;

    int err_cnt      = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int errs_before  = 0;
    int cycle_cnt    = 0;

    seq_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .result_v  (result_v),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Model and stimulus helpers
    //////////////////////////////////////////////////

    function automatic inst_word_t make_word(input opcode_e op, input logic [1:0] dst,
        input logic [1:0] src_a, input logic [1:0] src_b, input logic [IMM_WIDTH-1:0] imm);
        inst_word_t w;
        w.opcode = op;
        w.dst    = dst;
        w.src_a  = src_a;
        w.src_b  = src_b;
        w.imm    = imm;
        return w;
    endfunction

    // Run one word through the model and queue it for the burst
    function automatic void queue_word(input inst_word_t w);
        logic [DW-1:0]   a;
        logic [DW-1:0]   b;
        logic [2*DW-1:0] prod;
        a    = model_regs[w.src_a];
        b    = model_regs[w.src_b];
        prod = a * b;
        case (w.opcode)
            OP_LDI:  model_regs[w.dst] = DW'(w.imm);
            OP_ADD:  model_regs[w.dst] = a + b;
            OP_SUB:  model_regs[w.dst] = a - b;
            OP_MUL:  model_regs[w.dst] = prod[DW-1:0];
            OP_EMIT: exp_q.push_back(a);
            default: ;
        endcase
        burst_q.push_back(w);
    endfunction

    function automatic logic [1:0] rand_reg();
        return 2'($urandom());
    endfunction

    function automatic logic [IMM_WIDTH-1:0] rand_imm();
        return IMM_WIDTH'($urandom());
    endfunction

    function automatic int total_errors();
        return err_cnt + dut0.chk0.fail_cnt;
    endfunction

    // Stream the queued words back to back, wait for results, then hold the gap
    task automatic send_burst();
        for (int i = 0; i < burst_q.size(); i++) begin
            @(posedge clk);
            #1;
            inst_in_v = 1'b1;
            inst_in   = burst_q[i];
        end
        @(posedge clk);
        #1;
        inst_in_v = 1'b0;
        inst_in   = '0;
        burst_q.delete();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (`SEQ_REPLAY_DELAY + 4) @(posedge clk);
    endtask

    task automatic finish_test(input int num, input string name);
        int errs_now;
        errs_now = total_errors();
        if (errs_now == errs_before) begin
            tests_passed++;
            $display("Test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", num, name, errs_now - errs_before);
        end
        errs_before = errs_now;
    endtask

    //////////////////////////////////////////////////
    // Scoreboard and watchdog
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst && result_v) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Unexpected result 0x%h at %0t ns with none outstanding", result, $time);
            end else begin
                exp_val = exp_q.pop_front();
                assert (result == exp_val) else begin
                    err_cnt++;
                    $display("FAIL %0t ns: result 0x%h, expected 0x%h", $time, result, exp_val);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        rst       = 1'b1;
        inst_in_v = 1'b0;
        inst_in   = '0;
        for (int i = 0; i < 4; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(8));
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Quiet after reset, then r0 reads back zero
        repeat (20) @(posedge clk);
        queue_word(make_word(OP_EMIT, 2'd0, 2'd0, 2'd0, '0));
        send_burst();
        finish_test(1, "reset state");

        for (int r = 0; r < 4; r++) begin
            queue_word(make_word(OP_LDI, 2'(r), 2'd0, 2'd0, rand_imm()));
        end
        for (int r = 0; r < 4; r++) begin
            queue_word(make_word(OP_EMIT, 2'd0, 2'(r), 2'd0, '0));
        end
        send_burst();
        finish_test(2, "load and emit");

        // 0x3fff squared wraps, r2 + r2 overflows, 5 - 0x3fff underflows
        queue_word(make_word(OP_LDI, 2'd0, 2'd0, 2'd0, 14'h3fff));
        queue_word(make_word(OP_LDI, 2'd1, 2'd0, 2'd0, 14'd5));
        queue_word(make_word(OP_MUL, 2'd2, 2'd0, 2'd0, '0));
        queue_word(make_word(OP_ADD, 2'd3, 2'd2, 2'd2, '0));
        queue_word(make_word(OP_SUB, 2'd1, 2'd1, 2'd0, '0));
        queue_word(make_word(OP_EMIT, 2'd0, 2'd3, 2'd0, '0));
        queue_word(make_word(OP_MUL, 2'd0, 2'd3, 2'd1, '0));
        queue_word(make_word(OP_EMIT, 2'd0, 2'd0, 2'd0, '0));
        queue_word(make_word(OP_EMIT, 2'd0, 2'd2, 2'd0, '0));
        send_burst();
        finish_test(3, "arithmetic");

        // Full-length burst with EMITs spread through it
        for (int i = 0; i < MAX_BURST; i++) begin
            if (i % 2 == 0) begin
                queue_word(make_word(OP_EMIT, 2'd0, rand_reg(), 2'd0, '0));
            end else begin
                queue_word(make_word(OP_LDI, rand_reg(), 2'd0, 2'd0, rand_imm()));
            end
        end
        send_burst();
        finish_test(4, "replay timing");

        // Random burst at the following addresses, registers carried over
        queue_word(make_word(OP_EMIT, 2'd0, rand_reg(), 2'd0, '0));
        for (int i = 0; i < 6; i++) begin
            queue_word(make_word(opcode_e'($urandom_range(5, 0)), rand_reg(), rand_reg(),
                rand_reg(), rand_imm()));
        end
        queue_word(make_word(OP_EMIT, 2'd0, rand_reg(), 2'd0, '0));
        send_burst();
        finish_test(5, "second burst");

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
            tests_passed, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+src
src/seq_pkg.sv
src/inst_mem.sv
src/inst_decode.sv
src/reg_file.sv
src/exec_unit.sv
src/seq_top.sv
sim/seq_chk.sv
sim/seq_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the sequencer testbench with Verilator, run it, then scan the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
    --top-module seq_tb -f filelist.f -o seq_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/seq_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0
